/* switch_read.f */
rtl/switch_read_pkg.sv
rtl/crc32_accum.sv
rtl/port_queue_bank.sv
rtl/header_scan.sv
rtl/qos_arbiter.sv
rtl/frame_reader.sv
rtl/switch_read_top.sv
testbench/switch_read_model.sv
testbench/switch_read_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= switch_read_tb
FILELIST  ?= switch_read.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/switch_read_tb.sv */
`timescale 1ns/1ps

module switch_read_tb;

    logic                       clk;
    logic                       rst_n;
    logic                       in_vld;
    switch_read_pkg::in_word_t  in_word;
    logic                       qos_mode;
    logic                       link_en;
    logic                       out_vld;
    switch_read_pkg::out_word_t out_word;
    logic                       stat_vld;
    switch_read_pkg::status_t   status;

    integer     seed;
    int         tests_pass, tests_fail, err_mark, frames_sent;
    bit         stalled;       // set on the first timeout so later waits return at once
    logic [1:0] port_r;
    logic [7:0] pris;

    switch_read_top i_dut (
        .clk, .rst_n, .in_vld, .in_word, .qos_mode, .link_en,
        .out_vld, .out_word, .stat_vld, .status
    );

    switch_read_model i_model (.clk, .out_vld, .out_word, .stat_vld, .status);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // stimulus helpers
    task automatic send_frame(input logic [1:0] port, input logic [1:0] pri, input bit corrupt);
        logic [7:0]  len;
        logic [31:0] crc;
        logic [47:0] payload [16];
        int          n;
        len = 8'(1 + $unsigned($random(seed)) % 16);
        n = 0;
        // hold back until the port queue can take the whole frame
        while (i_model.pend_words[port] + len + 1 > switch_read_pkg::QUEUE_DEPTH
               && n < 5000 && !stalled) begin
            @(negedge clk);
            n++;
        end
        if (n >= 5000) begin
            $display("timeout: queue of port %0d never drained", port);
            stalled = 1'b1;
        end
        if (stalled) return;
        crc = switch_read_pkg::CRC_INIT;
        for (int i = 0; i < len; i++) begin
            payload[i] = 48'({$random(seed), $random(seed)});
            crc = i_model.crc_word(crc, payload[i]);
            i_model.add_word(port, payload[i]);
        end
        i_model.close_frame(port, len, !corrupt);
        if (corrupt) crc = crc ^ ($random(seed) | 32'h1);  // never a zero flip
        @(negedge clk);
        in_vld = 1'b1;
        in_word.port = port;
        in_word.last = 1'b0;
        in_word.data.hdr = '{rsvd: 6'd0, pri: pri, len: len, crc: crc};
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            in_word.last = (i == len - 1);
            in_word.data.raw = payload[i];
        end
        @(negedge clk);
        in_vld = 1'b0;
        frames_sent++;
    endtask

    task automatic wait_frames(input int limit, input string what);
        int n;
        n = 0;
        while (i_model.done_cnt < frames_sent && n < limit && !stalled) begin
            @(negedge clk);
            n++;
        end
        if (i_model.done_cnt < frames_sent && !stalled) begin
            $display("timeout: %s, only %0d of %0d frames came out", what,
                     i_model.done_cnt, frames_sent);
            stalled = 1'b1;
        end
    endtask

    // every port holds a pending descriptor
    task automatic wait_headers(input int limit);
        int n;
        n = 0;
        while (i_dut.desc_vld != 4'hF && n < limit && !stalled) begin
            @(negedge clk);
            n++;
        end
        if (i_dut.desc_vld != 4'hF && !stalled) begin
            $display("timeout: headers of all ports were never scanned");
            stalled = 1'b1;
        end
    endtask

    task automatic finish_test(input string name);
        if (i_model.err_cnt == err_mark && !stalled) begin
            $display("test %s: pass", name);
            tests_pass++;
        end else begin
            $display("test %s: FAIL", name);
            tests_fail++;
        end
        err_mark = i_model.err_cnt;
    endtask

    ////////////////////
    // test sequence
    initial begin
        seed = 32'h48e5_2b79;
        rst_n = 1'b0;
        in_vld = 1'b0;
        in_word = '0;
        qos_mode = 1'b0;
        link_en = 1'b0;
        tests_pass = 0;
        tests_fail = 0;
        err_mark = 0;
        frames_sent = 0;
        stalled = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        link_en = 1'b1;
        port_r = 2'($random(seed));
        send_frame(port_r, 2'($random(seed)), 1'b0);
        wait_frames(500, "single frame");
        i_model.check_value(i_model.last_port, port_r, "single frame port");
        finish_test("single frame");

        repeat (3) begin   // bad crc frame followed by a clean one on the same port
            port_r = 2'($random(seed));
            send_frame(port_r, 2'($random(seed)), 1'b1);
            send_frame(port_r, 2'($random(seed)), 1'b0);
        end
        wait_frames(2000, "crc error frames");
        finish_test("crc error detection");

        for (int m = 0; m < 2; m++) begin
            link_en = 1'b0;
            qos_mode = m[0];
            pris = 8'($random(seed));
            for (int p = 0; p < 4; p++) send_frame(2'(p), pris[2*p +: 2], 1'b0);
            wait_headers(200);
            i_model.plan_order(qos_mode, pris);
            link_en = 1'b1;
            wait_frames(1000, "ordered frames");
            finish_test(m == 0 ? "strict priority order" : "weighted round robin order");
        end

        qos_mode = 1'($random(seed));
        repeat (200) send_frame(2'($random(seed)), 2'($random(seed)), ($random(seed) & 7) == 0);
        wait_frames(20000, "random traffic");
        i_model.check_value(i_model.backlog(), 0, "frames still expected");
        finish_test("random traffic");

        $display("%0d tests passed, %0d tests failed", tests_pass, tests_fail);
        if (tests_fail == 0 && i_model.err_cnt == 0 && !stalled) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* testbench/switch_read_model.sv */
`timescale 1ns/1ps

module switch_read_model (
    input  logic                       clk,
    input  logic                       out_vld,
    input  switch_read_pkg::out_word_t out_word,
    input  logic                       stat_vld,
    input  switch_read_pkg::status_t   status
);

    logic [switch_read_pkg::WORD_W-1:0] exp_data [switch_read_pkg::NUM_PORTS][$];
    int   exp_len [switch_read_pkg::NUM_PORTS][$];
    logic exp_ok  [switch_read_pkg::NUM_PORTS][$];
    int   exp_order [$];   // empty unless a test fixes the grant order
    int   pend_words [switch_read_pkg::NUM_PORTS] = '{default: 0};  // header included
    int   credit [switch_read_pkg::NUM_PORTS] = '{default: 0};
    int   wrr_ptr = 0;
    int   err_cnt = 0;
    int   done_cnt = 0;
    int   last_port = 0;
    int   cur_port = 0;
    int   cur_len = 0;
    int   widx = 0;        // word position inside the current frame

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // crc-32, msb first, no reflection and no final xor
    function automatic logic [31:0] crc_word(input logic [31:0] crc, input logic [47:0] word);
        logic [31:0] c;
        c = crc;
        for (int b = 47; b >= 0; b--) begin
            if (c[31] ^ word[b]) c = (c << 1) ^ switch_read_pkg::CRC_POLY;
            else c = c << 1;
        end
        return c;
    endfunction

    task automatic add_word(input int port, input logic [47:0] word);
        exp_data[port].push_back(word);
    endtask

    task automatic close_frame(input int port, input int len, input logic ok);
        exp_len[port].push_back(len);
        exp_ok[port].push_back(ok);
        pend_words[port] += len + 1;
    endtask

    function automatic int backlog();
        int n;
        n = 0;
        for (int p = 0; p < switch_read_pkg::NUM_PORTS; p++) begin
            n += exp_data[p].size() + exp_len[p].size();
        end
        return n;
    endfunction

    // grant sequence for one frame pending on every port
    task automatic plan_order(input logic mode, input logic [7:0] pris);
        logic [3:0] pend;
        int         pick;
        int         idx;
        bit         reload;
        pend = 4'hF;
        repeat (switch_read_pkg::NUM_PORTS) begin
            pick = -1;
            if (!mode) begin
                for (int p = 0; p < 4; p++) begin
                    if (pend[p] && (pick < 0 || pris[2*p +: 2] > pris[2*pick +: 2])) pick = p;
                end
            end else begin
                reload = 1'b1;
                for (int p = 0; p < 4; p++) if (pend[p] && credit[p] > 0) reload = 1'b0;
                for (int p = 0; p < 4; p++) begin
                    if (reload && pend[p]) credit[p] = pris[2*p +: 2] + 1;
                end
                for (int k = 0; k < 4; k++) begin
                    idx = (wrr_ptr + k) % 4;
                    if (pick < 0 && pend[idx] && credit[idx] > 0) pick = idx;
                end
                credit[pick]--;
                wrr_ptr = (credit[pick] == 0) ? (pick + 1) % 4 : pick;  // stay while credit lasts
            end
            exp_order.push_back(pick);
            pend[pick] = 1'b0;
        end
    endtask

    // outputs only move on posedge, so sample mid-cycle
    always @(negedge clk) begin
        if (out_vld) begin
            if (widx == 0) begin
                cur_port = out_word.port;
                cur_len  = (exp_len[cur_port].size() > 0) ? exp_len[cur_port][0] : 0;
            end
            if (cur_len == 0 || exp_data[cur_port].size() == 0) begin
                $display("unexpected word on port %0d at %0t", out_word.port, $time);
                err_cnt++;
            end else begin
                check_value(out_word.port, cur_port, "word port");
                check_value(out_word.sop, widx == 0, "sop marker");
                check_value(out_word.eop, widx == cur_len - 1, "eop marker");
                check_value(out_word.data, exp_data[cur_port].pop_front(), "payload word");
                widx = (widx == cur_len - 1) ? 0 : widx + 1;
            end
        end
        if (stat_vld) begin
            if (exp_ok[status.port].size() == 0) begin
                $display("status for port %0d with no frame pending at %0t", status.port, $time);
                err_cnt++;
            end else begin
                check_value(status.port, cur_port, "status port");
                check_value(status.crc_ok, exp_ok[status.port].pop_front(), "crc status");
                pend_words[status.port] -= exp_len[status.port].pop_front() + 1;
                if (exp_order.size() > 0) begin
                    check_value(status.port, exp_order.pop_front(), "grant order");
                end
            end
            last_port = status.port;
            done_cnt++;
        end
    end

endmodule

/* rtl/switch_read_top.sv */
`timescale 1ns/1ps

module switch_read_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_vld,
    input  switch_read_pkg::in_word_t   in_word,
    input  logic                        qos_mode,
    input  logic                        link_en,
    output logic                        out_vld,
    output switch_read_pkg::out_word_t  out_word,
    output logic                        stat_vld,
    output switch_read_pkg::status_t    status
);

    logic                                  scan_rd, scan_ack, rdr_rd;
    logic [switch_read_pkg::PORT_W-1:0]    scan_port, rdr_port, grant_port, done_port;
    switch_read_pkg::queue_word_u          rd_data;
    logic [switch_read_pkg::NUM_PORTS-1:0] frame_avail, desc_vld;
    switch_read_pkg::desc_t [switch_read_pkg::NUM_PORTS-1:0] desc;
    logic                                  grant_vld, reader_busy, done_vld;

    port_queue_bank i_bank (
        .clk, .rst_n, .in_vld, .in_word,
        .scan_rd, .scan_port, .rdr_rd, .rdr_port,
        .scan_ack, .rd_data, .frame_avail
    );

    header_scan i_scan (
        .clk, .rst_n, .frame_avail, .scan_ack, .rd_data,
        .done_vld, .done_port,
        .scan_rd, .scan_port, .desc_vld, .desc
    );

    qos_arbiter i_arb (
        .clk, .rst_n, .qos_mode, .link_en, .reader_busy,
        .desc_vld, .desc, .grant_vld, .grant_port
    );

    frame_reader i_reader (
        .clk, .rst_n, .grant_vld, .grant_port, .desc, .rd_data,
        .rdr_rd, .rdr_port, .reader_busy,
        .out_vld, .out_word, .stat_vld, .status,
        .done_vld, .done_port
    );

endmodule

/* rtl/frame_reader.sv */
`timescale 1ns/1ps

module frame_reader (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    grant_vld,
    input  logic [switch_read_pkg::PORT_W-1:0]      grant_port,
    input  switch_read_pkg::desc_t [switch_read_pkg::NUM_PORTS-1:0] desc,
    input  switch_read_pkg::queue_word_u            rd_data,
    output logic                                    rdr_rd,
    output logic [switch_read_pkg::PORT_W-1:0]      rdr_port,
    output logic                                    reader_busy,
    output logic                                    out_vld,
    output switch_read_pkg::out_word_t              out_word,
    output logic                                    stat_vld,
    output switch_read_pkg::status_t                status,
    output logic                                    done_vld,
    output logic [switch_read_pkg::PORT_W-1:0]      done_port
);

    logic                               busy;
    logic                               data_vld;   // rd_data holds payload
    logic                               sop_pend;
    logic                               last_word;
    logic [switch_read_pkg::LEN_W-1:0]  rd_left;    // reads still to issue
    logic [switch_read_pkg::LEN_W-1:0]  out_left;   // words still to forward
    logic [switch_read_pkg::PORT_W-1:0] cur_port;
    logic [switch_read_pkg::CRC_W-1:0]  exp_crc;
    logic [switch_read_pkg::CRC_W-1:0]  crc_val;

    crc32_accum i_crc (
        .clk   (clk),
        .rst_n (rst_n),
        .clr   (grant_vld),
        .en    (data_vld),
        .data  (rd_data.raw),
        .crc   (crc_val)
    );

    assign rdr_rd      = rd_left != 0;
    assign rdr_port    = cur_port;
    assign reader_busy = busy;
    assign last_word   = data_vld && out_left == 1;

    ////////////////////
    // egress stream
    assign out_vld  = data_vld;
    assign out_word = '{port: cur_port, sop: data_vld && sop_pend, eop: last_word,
                        data: rd_data.raw};
    assign done_vld  = last_word;  // lets the scan clear the port before the next grant
    assign done_port = cur_port;
    assign status    = '{port: cur_port, crc_ok: crc_val == exp_crc};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            data_vld <= 1'b0;
            sop_pend <= 1'b0;
            rd_left  <= '0;
            out_left <= '0;
            stat_vld <= 1'b0;
        end else begin
            data_vld <= rdr_rd;
            stat_vld <= last_word;  // crc settles one cycle after eop
            if (grant_vld) begin
                busy     <= 1'b1;
                sop_pend <= 1'b1;
                rd_left  <= desc[grant_port].len;
                out_left <= desc[grant_port].len;
            end else begin
                if (rdr_rd) rd_left <= rd_left - 1'b1;
                if (data_vld) begin
                    sop_pend <= 1'b0;
                    out_left <= out_left - 1'b1;
                end
                if (last_word) busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_vld) begin
            cur_port <= grant_port;
            exp_crc  <= desc[grant_port].crc;
        end
    end

    a_eop_after_reads: assert property (@(posedge clk) disable iff (!rst_n)
        out_word.eop |-> !rdr_rd);
    a_grant_idle: assert property (@(posedge clk) disable iff (!rst_n)
        grant_vld |-> !busy);

endmodule

/* rtl/qos_arbiter.sv */
`timescale 1ns/1ps

module qos_arbiter (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    qos_mode,     // 0 strict, 1 wrr
    input  logic                                    link_en,
    input  logic                                    reader_busy,
    input  logic [switch_read_pkg::NUM_PORTS-1:0]   desc_vld,
    input  switch_read_pkg::desc_t [switch_read_pkg::NUM_PORTS-1:0] desc,
    output logic                                    grant_vld,
    output logic [switch_read_pkg::PORT_W-1:0]      grant_port
);

    logic [switch_read_pkg::PRI_W:0]       credit     [switch_read_pkg::NUM_PORTS];
    logic [switch_read_pkg::PRI_W:0]       eff_credit [switch_read_pkg::NUM_PORTS];
    logic [switch_read_pkg::NUM_PORTS-1:0] has_credit, wrr_req;
    logic                                  reload;
    logic [switch_read_pkg::PORT_W-1:0]    wrr_ptr, sp_port, pick_port;
    logic [switch_read_pkg::PORT_W:0]      wrr_pick;
    logic                                  sp_found;
    logic                                  decide;

    always_comb begin
        for (int p = 0; p < switch_read_pkg::NUM_PORTS; p++) begin
            has_credit[p] = credit[p] != 0;
        end
        reload = ~|(desc_vld & has_credit);  // every pending port is out of credit
        for (int p = 0; p < switch_read_pkg::NUM_PORTS; p++) begin
            eff_credit[p] = reload ? {1'b0, desc[p].pri} + 1'b1 : credit[p];
            wrr_req[p]    = desc_vld[p] && eff_credit[p] != 0;
        end
        // strict priority, walking down so ties land on the lowest port
        sp_port  = '0;
        sp_found = 1'b0;
        for (int p = switch_read_pkg::NUM_PORTS - 1; p >= 0; p--) begin
            if (desc_vld[p] && (!sp_found || desc[p].pri >= desc[sp_port].pri)) begin
                sp_port  = switch_read_pkg::PORT_W'(p);
                sp_found = 1'b1;
            end
        end
    end

    assign wrr_pick  = switch_read_pkg::rr_pick(wrr_req, wrr_ptr);
    assign pick_port = qos_mode ? wrr_pick[switch_read_pkg::PORT_W-1:0] : sp_port;
    // grant_vld term covers the cycle before reader_busy rises
    assign decide    = link_en && !reader_busy && !grant_vld && |desc_vld;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_vld  <= 1'b0;
            grant_port <= '0;
            wrr_ptr    <= '0;
            for (int p = 0; p < switch_read_pkg::NUM_PORTS; p++) credit[p] <= '0;
        end else begin
            grant_vld <= decide;
            if (decide) grant_port <= pick_port;
            if (decide && qos_mode) begin
                for (int p = 0; p < switch_read_pkg::NUM_PORTS; p++) begin
                    if (reload && desc_vld[p]) credit[p] <= eff_credit[p];
                end
                credit[pick_port] <= eff_credit[pick_port] - 1'b1;
                if (eff_credit[pick_port] == 1) wrr_ptr <= pick_port + 1'b1;
                else wrr_ptr <= pick_port;
            end
        end
    end

    a_grant_pending: assert property (@(posedge clk) disable iff (!rst_n)
        grant_vld |-> desc_vld[grant_port]);

endmodule

/* rtl/header_scan.sv */
`timescale 1ns/1ps

module header_scan (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [switch_read_pkg::NUM_PORTS-1:0]   frame_avail,
    input  logic                                    scan_ack,
    input  switch_read_pkg::queue_word_u            rd_data,
    input  logic                                    done_vld,
    input  logic [switch_read_pkg::PORT_W-1:0]      done_port,
    output logic                                    scan_rd,
    output logic [switch_read_pkg::PORT_W-1:0]      scan_port,
    output logic [switch_read_pkg::NUM_PORTS-1:0]   desc_vld,
    output switch_read_pkg::desc_t [switch_read_pkg::NUM_PORTS-1:0] desc
);

    logic [switch_read_pkg::PORT_W-1:0]    ptr;
    logic [switch_read_pkg::NUM_PORTS-1:0] eligible;
    logic [switch_read_pkg::PORT_W:0]      pick;
    logic                                  cap_vld;   // header on rd_data this cycle
    logic [switch_read_pkg::PORT_W-1:0]    cap_port;

    always_comb begin
        eligible = frame_avail & ~desc_vld;
        // header in flight, count not yet visible in desc_vld
        if (cap_vld) eligible[cap_port] = 1'b0;
    end

    assign pick      = switch_read_pkg::rr_pick(eligible, ptr);
    assign scan_rd   = pick[switch_read_pkg::PORT_W];
    assign scan_port = pick[switch_read_pkg::PORT_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr      <= '0;
            cap_vld  <= 1'b0;
            cap_port <= '0;
            desc_vld <= '0;
        end else begin
            cap_vld <= scan_ack;
            if (scan_ack) begin
                ptr      <= scan_port + 1'b1;  // rotate past the served port
                cap_port <= scan_port;
            end
            if (done_vld) desc_vld[done_port] <= 1'b0;
            if (cap_vld) desc_vld[cap_port] <= 1'b1;
        end
    end

    ////////////////////
    // descriptor payload
    always_ff @(posedge clk) begin
        if (cap_vld) begin
            desc[cap_port] <= {rd_data.hdr.pri, rd_data.hdr.len, rd_data.hdr.crc};
        end
    end

    a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
        cap_vld |-> !desc_vld[cap_port]);

endmodule

/* rtl/port_queue_bank.sv */
`timescale 1ns/1ps

module port_queue_bank (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    in_vld,
    input  switch_read_pkg::in_word_t               in_word,
    input  logic                                    scan_rd,
    input  logic [switch_read_pkg::PORT_W-1:0]      scan_port,
    input  logic                                    rdr_rd,
    input  logic [switch_read_pkg::PORT_W-1:0]      rdr_port,
    output logic                                    scan_ack,
    output switch_read_pkg::queue_word_u            rd_data,
    output logic [switch_read_pkg::NUM_PORTS-1:0]   frame_avail
);

    // all queues share one array, port index is the upper address bits
    logic [switch_read_pkg::WORD_W-1:0] mem [switch_read_pkg::NUM_PORTS*switch_read_pkg::QUEUE_DEPTH];
    logic [switch_read_pkg::ADDR_W-1:0] wr_ptr    [switch_read_pkg::NUM_PORTS];
    logic [switch_read_pkg::ADDR_W-1:0] rd_ptr    [switch_read_pkg::NUM_PORTS];
    logic [switch_read_pkg::ADDR_W:0]   occ       [switch_read_pkg::NUM_PORTS];
    logic [switch_read_pkg::ADDR_W:0]   frame_cnt [switch_read_pkg::NUM_PORTS];
    logic [switch_read_pkg::NUM_PORTS-1:0] wr_hit, rd_hit, last_hit, ack_hit;
    logic                                  rd_en;
    logic [switch_read_pkg::PORT_W-1:0]    rd_sel;

    assign rd_en    = rdr_rd | scan_rd;
    assign rd_sel   = rdr_rd ? rdr_port : scan_port;  // reader has priority
    assign scan_ack = scan_rd & ~rdr_rd;

    always_comb begin
        for (int p = 0; p < switch_read_pkg::NUM_PORTS; p++) begin
            wr_hit[p]      = in_vld && in_word.port == p;
            rd_hit[p]      = rd_en && rd_sel == p;
            last_hit[p]    = wr_hit[p] && in_word.last;
            ack_hit[p]     = scan_ack && scan_port == p;
            frame_avail[p] = frame_cnt[p] != 0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_vld) mem[{in_word.port, wr_ptr[in_word.port]}] <= in_word.data.raw;
        if (rd_en) rd_data.raw <= mem[{rd_sel, rd_ptr[rd_sel]}];
    end

    ////////////////////
    // pointers and counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < switch_read_pkg::NUM_PORTS; p++) begin
                wr_ptr[p]    <= '0;
                rd_ptr[p]    <= '0;
                occ[p]       <= '0;
                frame_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < switch_read_pkg::NUM_PORTS; p++) begin
                if (wr_hit[p]) wr_ptr[p] <= wr_ptr[p] + 1'b1;
                if (rd_hit[p]) rd_ptr[p] <= rd_ptr[p] + 1'b1;
                case ({wr_hit[p], rd_hit[p]})
                    2'b10:   occ[p] <= occ[p] + 1'b1;
                    2'b01:   occ[p] <= occ[p] - 1'b1;
                    default: ;
                endcase
                // a frame stops counting once its header is taken
                case ({last_hit[p], ack_hit[p]})
                    2'b10:   frame_cnt[p] <= frame_cnt[p] + 1'b1;
                    2'b01:   frame_cnt[p] <= frame_cnt[p] - 1'b1;
                    default: ;
                endcase
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        in_vld |-> occ[in_word.port] != switch_read_pkg::QUEUE_DEPTH);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> occ[rd_sel] != 0);

endmodule

/* rtl/crc32_accum.sv */
`timescale 1ns/1ps

module crc32_accum (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 clr,
    input  logic                                 en,
    input  logic [switch_read_pkg::WORD_W-1:0]   data,
    output logic [switch_read_pkg::CRC_W-1:0]    crc
);

    logic [switch_read_pkg::CRC_W-1:0] crc_nxt;
    logic                              fb;

    // msb first, one bit per step over the whole word
    always_comb begin
        crc_nxt = crc;
        fb      = 1'b0;
        for (int i = switch_read_pkg::WORD_W - 1; i >= 0; i--) begin
            fb      = crc_nxt[switch_read_pkg::CRC_W-1] ^ data[i];
            crc_nxt = {crc_nxt[switch_read_pkg::CRC_W-2:0], 1'b0};
            if (fb) crc_nxt = crc_nxt ^ switch_read_pkg::CRC_POLY;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= switch_read_pkg::CRC_INIT;
        end else if (clr) begin
            crc <= switch_read_pkg::CRC_INIT;  // start of a new frame
        end else if (en) begin
            crc <= crc_nxt;
        end
    end

endmodule

/* rtl/switch_read_pkg.sv */
package switch_read_pkg;

    localparam int NUM_PORTS   = 4;
    localparam int PORT_W      = 2;
    localparam int WORD_W      = 48;
    localparam int PRI_W       = 2;
    localparam int LEN_W       = 8;
    localparam int CRC_W       = 32;
    localparam int QUEUE_DEPTH = 64;
    localparam int ADDR_W      = $clog2(QUEUE_DEPTH);
    localparam logic [CRC_W-1:0] CRC_POLY = 32'h04C11DB7;
    localparam logic [CRC_W-1:0] CRC_INIT = 32'hFFFFFFFF;

    typedef struct packed {
        logic [5:0]       rsvd;
        logic [PRI_W-1:0] pri;
        logic [LEN_W-1:0] len;  // payload words, header excluded
        logic [CRC_W-1:0] crc;
    } hdr_t;

    // one queue word, payload or header depending on position in frame
    typedef union packed {
        logic [WORD_W-1:0] raw;
        hdr_t              hdr;
    } queue_word_u;

    typedef struct packed {
        logic [PORT_W-1:0] port;
        logic              last;
        queue_word_u       data;
    } in_word_t;

    typedef struct packed {
        logic [PRI_W-1:0] pri;
        logic [LEN_W-1:0] len;
        logic [CRC_W-1:0] crc;
    } desc_t;

    typedef struct packed {
        logic [PORT_W-1:0] port;
        logic              sop;
        logic              eop;
        logic [WORD_W-1:0] data;
    } out_word_t;

    typedef struct packed {
        logic [PORT_W-1:0] port;
        logic              crc_ok;
    } status_t;

    // first requesting port at or after ptr, msb of result is the hit flag
    function automatic logic [PORT_W:0] rr_pick(input logic [NUM_PORTS-1:0] req,
                                                input logic [PORT_W-1:0] ptr);
        logic [PORT_W-1:0] idx;
        logic [PORT_W:0]   pick;
        pick = '0;
        for (int i = NUM_PORTS - 1; i >= 0; i--) begin
            idx = ptr + PORT_W'(i);
            if (req[idx]) pick = {1'b1, idx};  // lowest offset written last
        end
        return pick;
    endfunction

endpackage
